// File: Makefile
# Verilator build and run of the serial bus testbench
VERILATOR ?= verilator
TOP       ?= tb_bus_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

SRCS    := $(filter-out +%,$(shell cat $(FLIST)))
HDRS    := $(wildcard logic/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+logic
logic/bus_pkg.sv
logic/bus_arbiter.sv
logic/bus_master.sv
logic/memory_slave.sv
logic/bus_top.sv
tests/tb_bus_top.sv

// File: logic/bus_arbiter.sv
// fixed-priority arbiter for the shared serial bus
// lowest master index wins, grant held until the frame ends
`timescale 1ns/1ns
`include "bus_defs.svh"

module bus_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`BUS_NUM_MASTERS-1:0] req,
    input  logic                        bus_busy,
    output logic [`BUS_NUM_MASTERS-1:0] grant
);

    logic [`BUS_NUM_MASTERS-1:0] grant_q;
    logic [`BUS_NUM_MASTERS-1:0] pick;
    // busy of the previous cycle, for the falling edge
    logic                        busy_d;
    logic                        busy_fall;
    logic                        grant_held;

    // isolate the lowest set request bit
    assign pick = req & (~req + 1'b1);

    assign busy_fall  = busy_d & ~bus_busy;
    assign grant_held = |grant_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= '0;
            busy_d  <= 1'b0;
        end else begin
            busy_d <= bus_busy;
            if (grant_held) begin
                // owner done, free the bus
                // next arbitration one cycle later
                if (busy_fall) begin
                    grant_q <= '0;
                end
            end else if (!bus_busy) begin
                // free bus, one cycle after the request
                grant_q <= pick;
            end
        end
    end

    assign grant = grant_q;

endmodule

// File: logic/bus_defs.svh
// bus width macros
// master count and the slave ids of the two memory slaves
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// serial payload widths
`define BUS_DATA_W 8
`define BUS_ID_W 3
// address inside one slave, 4 KB
`define BUS_ADDR_W 12

// agents on the shared line
`define BUS_NUM_MASTERS 2

// ids owned by the memory slaves
// any other id reads back all ones
`define BUS_SLAVE_A_ID 3
`define BUS_SLAVE_B_ID 4

`endif

// File: logic/bus_master.sv
// serial bus master
// latches one command, requests the bus, shifts id, addr and data out
// collects the read byte and pulses the response
`timescale 1ns/1ns
`include "bus_defs.svh"

module bus_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 execute,
    input  bus_pkg::master_cmd_t cmd,
    input  logic                 grant,
    input  logic                 bus_line,
    output logic                 req,
    output logic                 bus_out,
    output logic                 rw,
    output logic                 busy,
    output bus_pkg::master_rsp_t rsp
);
    import bus_pkg::*;

    localparam int SHIFT_W = `BUS_ID_W + `BUS_ADDR_W + `BUS_DATA_W;
    // widest phase is the address
    localparam int CNT_W = $clog2(`BUS_ADDR_W);

    frame_phase_t           phase_q;
    logic [CNT_W-1:0]       bit_cnt_q;
    logic                   req_q;
    logic                   busy_q;
    master_cmd_t            cmd_q;
    logic [SHIFT_W-1:0]     shift_q;
    logic [`BUS_DATA_W-1:0] rdata_q;
    logic                   accept;
    logic                   last_bit;
    logic                   sending;

    // new command only when fully idle
    assign accept = (phase_q == PH_IDLE) && !req_q && execute;

    // last bit of the current phase
    always_comb begin
        case (phase_q)
            PH_ID:   last_bit = (bit_cnt_q == CNT_W'(`BUS_ID_W - 1));
            PH_ADDR: last_bit = (bit_cnt_q == CNT_W'(`BUS_ADDR_W - 1));
            PH_TURN: last_bit = 1'b1;
            PH_DATA: last_bit = (bit_cnt_q == CNT_W'(`BUS_DATA_W - 1));
            default: last_bit = 1'b0;
        endcase
    end

    // master drives the line in id, addr and write data cycles
    assign sending = (phase_q == PH_ID) || (phase_q == PH_ADDR) ||
                     ((phase_q == PH_DATA) && cmd_q.rw);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q   <= PH_IDLE;
            bit_cnt_q <= '0;
            req_q     <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (accept) begin
                        req_q <= 1'b1;
                    end else if (req_q && grant) begin
                        // first busy cycle carries the id MSB
                        busy_q    <= 1'b1;
                        phase_q   <= PH_ID;
                        bit_cnt_q <= '0;
                    end
                end
                // response cycle, back to idle
                PH_DONE: phase_q <= PH_IDLE;
                default: begin
                    if (last_bit) begin
                        bit_cnt_q <= '0;
                        case (phase_q)
                            PH_ID:   phase_q <= PH_ADDR;
                            // reads insert one turnaround cycle
                            PH_ADDR: phase_q <= cmd_q.rw ? PH_DATA : PH_TURN;
                            PH_TURN: phase_q <= PH_DATA;
                            default: begin
                                phase_q <= PH_DONE;
                                busy_q  <= 1'b0;
                                req_q   <= 1'b0;
                            end
                        endcase
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q   <= cmd;
            shift_q <= {cmd.slave_id, cmd.addr, cmd.wdata};
        end else if (sending) begin
            shift_q <= {shift_q[SHIFT_W-2:0], 1'b1};
        end
        // write echoes its own byte, read samples the line
        if (phase_q == PH_DATA) begin
            if (cmd_q.rw) begin
                rdata_q <= cmd_q.wdata;
            end else begin
                rdata_q <= {rdata_q[`BUS_DATA_W-2:0], bus_line};
            end
        end
    end

    // idle high when not sending
    assign bus_out   = sending ? shift_q[SHIFT_W-1] : 1'b1;
    // rw low unless this master owns the frame
    assign rw        = busy_q & cmd_q.rw;
    assign req       = req_q;
    assign busy      = busy_q;
    assign rsp.valid = (phase_q == PH_DONE);
    assign rsp.rdata = rdata_q;

endmodule

// File: logic/bus_pkg.sv
// shared types of the serial bus
// master command, master response and frame phase encoding
`include "bus_defs.svh"

package bus_pkg;

    // one parallel command, sent MSB first as id, addr, data
    typedef struct packed {
        logic                   rw;
        logic [`BUS_ID_W-1:0]   slave_id;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
    } master_cmd_t;

    // valid is a one cycle done pulse
    typedef struct packed {
        logic                   valid;
        logic [`BUS_DATA_W-1:0] rdata;
    } master_rsp_t;

    // phases of one frame, seen by master and slave alike
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ID,
        PH_ADDR,
        PH_TURN,
        PH_DATA,
        PH_DONE
    } frame_phase_t;

endpackage

// File: logic/bus_top.sv
// serial bus subsystem top
// arbiter, two masters and two memory slaves
// wired-AND data line, OR of rw and busy
`timescale 1ns/1ns
`include "bus_defs.svh"

module bus_top (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [`BUS_NUM_MASTERS-1:0]                  execute,
    input  bus_pkg::master_cmd_t [`BUS_NUM_MASTERS-1:0]  cmd,
    output bus_pkg::master_rsp_t [`BUS_NUM_MASTERS-1:0]  rsp,
    output logic                                         current_master,
    output logic                                         bus_busy
);

    localparam int NUM_SLAVES = 2;

    logic [`BUS_NUM_MASTERS-1:0] req;
    logic [`BUS_NUM_MASTERS-1:0] grant;
    logic [`BUS_NUM_MASTERS-1:0] master_out;
    logic [`BUS_NUM_MASTERS-1:0] master_rw;
    logic [`BUS_NUM_MASTERS-1:0] master_busy;
    logic [NUM_SLAVES-1:0]       slave_out;
    logic                        bus_line;
    logic                        bus_rw;

    bus_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .bus_busy (bus_busy),
        .grant    (grant)
    );

    for (genvar i = 0; i < `BUS_NUM_MASTERS; i++) begin : g_master
        bus_master u_master (
            .clk      (clk),
            .rst_n    (rst_n),
            .execute  (execute[i]),
            .cmd      (cmd[i]),
            .grant    (grant[i]),
            .bus_line (bus_line),
            .req      (req[i]),
            .bus_out  (master_out[i]),
            .rw       (master_rw[i]),
            .busy     (master_busy[i]),
            .rsp      (rsp[i])
        );
    end

    memory_slave #(
        .SELF_ID (`BUS_ID_W'(`BUS_SLAVE_A_ID))
    ) u_slave_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_line (bus_line),
        .bus_rw   (bus_rw),
        .bus_busy (bus_busy),
        .bus_out  (slave_out[0])
    );

    memory_slave #(
        .SELF_ID (`BUS_ID_W'(`BUS_SLAVE_B_ID))
    ) u_slave_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_line (bus_line),
        .bus_rw   (bus_rw),
        .bus_busy (bus_busy),
        .bus_out  (slave_out[1])
    );

    // idle high line, any agent can pull it low
    assign bus_line = (&master_out) & (&slave_out);
    // only the owner can raise rw or busy
    assign bus_rw   = |master_rw;
    assign bus_busy = |master_busy;

    // one-hot grant to index, 0 when no grant
    always_comb begin
        current_master = 1'b0;
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (grant[i]) begin
                current_master = i[0];
            end
        end
    end

endmodule

// File: logic/memory_slave.sv
// 4 KB memory slave on the serial bus
// follows each frame from the rise of busy, decodes id and address
// writes the data byte or drives the stored byte back on a read
`timescale 1ns/1ns
`include "bus_defs.svh"

module memory_slave #(
    parameter logic [`BUS_ID_W-1:0] SELF_ID = `BUS_SLAVE_A_ID
) (
    input  logic clk,
    input  logic rst_n,
    input  logic bus_line,
    input  logic bus_rw,
    input  logic bus_busy,
    output logic bus_out
);
    import bus_pkg::*;

    localparam int ID_END    = `BUS_ID_W;
    localparam int ADDR_END  = `BUS_ID_W + `BUS_ADDR_W;
    // frame length of a read incl. turnaround
    localparam int CNT_W     = $clog2(ADDR_END + 1 + `BUS_DATA_W + 1);
    localparam int MEM_DEPTH = 1 << `BUS_ADDR_W;

    logic [CNT_W-1:0]       cnt_q;
    logic                   rw_q;
    logic [`BUS_ID_W-1:0]   id_sr;
    logic [`BUS_ADDR_W-1:0] addr_sr;
    logic [`BUS_DATA_W-1:0] wr_sr;
    logic [`BUS_DATA_W-1:0] rd_sr;
    logic [`BUS_DATA_W-1:0] mem [MEM_DEPTH];
    frame_phase_t           phase;
    logic                   id_match;
    logic                   rd_active;
    logic                   mem_we;

    // cnt_q equals the frame cycle index while busy is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
            rw_q  <= 1'b0;
        end else begin
            cnt_q <= bus_busy ? cnt_q + 1'b1 : '0;
            // rw gone in the done cycle, keep a copy
            if (bus_busy) begin
                rw_q <= bus_rw;
            end
        end
    end

    always_comb begin
        if (!bus_busy) begin
            // first non-busy cycle after a frame
            phase = (cnt_q != '0) ? PH_DONE : PH_IDLE;
        end else if (cnt_q < CNT_W'(ID_END)) begin
            phase = PH_ID;
        end else if (cnt_q < CNT_W'(ADDR_END)) begin
            phase = PH_ADDR;
        end else if ((cnt_q == CNT_W'(ADDR_END)) && !bus_rw) begin
            phase = PH_TURN;
        end else begin
            phase = PH_DATA;
        end
    end

    assign id_match  = (id_sr == SELF_ID);
    assign rd_active = (phase == PH_DATA) && !bus_rw && id_match;
    // commit in the cycle the master pulses its response
    assign mem_we    = (phase == PH_DONE) && rw_q && id_match;

    // header and write data, MSB first
    always_ff @(posedge clk) begin
        case (phase)
            PH_ID:   id_sr   <= {id_sr[`BUS_ID_W-2:0], bus_line};
            PH_ADDR: addr_sr <= {addr_sr[`BUS_ADDR_W-2:0], bus_line};
            PH_DATA: begin
                if (bus_rw) begin
                    wr_sr <= {wr_sr[`BUS_DATA_W-2:0], bus_line};
                end
            end
            default: ;
        endcase
    end

    // byte array, read fetched during the turnaround
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[addr_sr] <= wr_sr;
        end
        if (phase == PH_TURN) begin
            rd_sr <= mem[addr_sr];
        end else if (rd_active) begin
            rd_sr <= {rd_sr[`BUS_DATA_W-2:0], 1'b1};
        end
    end

    // released high unless answering a read
    assign bus_out = rd_active ? rd_sr[`BUS_DATA_W-1] : 1'b1;

endmodule

// File: tests/bus_cases.txt
# name mask | master 0: rw id addr wdata exp | master 1: rw id addr wdata exp
# all fields hex, rw 1 is a write, mask bit i selects master i, exp is the expected rdata
wr_a_m0    1 1 3 010 5a 5a 0 0 000 00 00
rd_a_m0    1 0 3 010 00 5a 0 0 000 00 00
wr_b_m1    2 0 0 000 00 00 1 4 010 c3 c3
rd_b_m1    2 0 0 000 00 00 0 4 010 00 c3
rd_a_m1    2 0 0 000 00 00 0 3 010 00 5a
wr_a_m1    2 0 0 000 00 00 1 3 abc 81 81
rd_a_m0b   1 0 3 abc 00 81 0 0 000 00 00
rd_none_m0 1 0 0 123 00 ff 0 0 000 00 00
rd_none_m1 2 0 0 000 00 00 0 7 fff 00 ff
both_wr    3 1 3 fff 3c 3c 1 4 fff e7 e7
both_rd    3 0 3 fff 00 3c 0 4 fff 00 e7
both_mix   3 0 4 010 00 c3 1 3 010 a5 a5
rd_a_last  1 0 3 010 00 a5 0 0 000 00 00
rd_b_last  2 0 0 000 00 00 0 4 010 00 c3

// File: tests/tb_bus_top.sv
// testbench for the serial bus subsystem
// case file reader, response monitor, value check and watchdog
`timescale 1ns/1ns
`include "bus_defs.svh"

module tb_bus_top;
    import bus_pkg::*;

    localparam int MAX_CASES = 64;
    // cycle budget per case, also sizes the watchdog
    localparam int CASE_CYCLES = 80;

    logic                               clk;
    logic                               rst_n;
    logic [`BUS_NUM_MASTERS-1:0]        execute;
    master_cmd_t [`BUS_NUM_MASTERS-1:0] cmd;
    master_rsp_t [`BUS_NUM_MASTERS-1:0] rsp;
    logic                               current_master;
    logic                               bus_busy;

    // case table from the file
    logic [127:0]           case_name [MAX_CASES];
    logic [1:0]             case_mask [MAX_CASES];
    master_cmd_t            case_cmd  [MAX_CASES][`BUS_NUM_MASTERS];
    logic [`BUS_DATA_W-1:0] case_exp  [MAX_CASES][`BUS_NUM_MASTERS];
    int                     num_cases;
    bit                     table_ready;

    // monitor state, written with nonblocking updates on the falling edge
    int                     rsp_cnt   [`BUS_NUM_MASTERS];
    logic [`BUS_DATA_W-1:0] rsp_data  [`BUS_NUM_MASTERS];
    int                     rsp_stamp [`BUS_NUM_MASTERS];
    int                     cycle_q;
    int                     frame_cnt;
    logic [7:0]             owner_hist;
    logic                   busy_d;

    int err_cnt;
    int check_cnt;
    int exp_cnt [`BUS_NUM_MASTERS];

    bus_top u_bus_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .execute        (execute),
        .cmd            (cmd),
        .rsp            (rsp),
        .current_master (current_master),
        .bus_busy       (bus_busy)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (!rst_n) begin
            cycle_q    <= 0;
            frame_cnt  <= 0;
            owner_hist <= '0;
            busy_d     <= 1'b0;
            for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
                rsp_cnt[i]   <= 0;
                rsp_data[i]  <= '0;
                rsp_stamp[i] <= 0;
            end
        end else begin
            cycle_q <= cycle_q + 1;
            busy_d  <= bus_busy;
            // owner index seen at the start of each frame
            if (bus_busy && !busy_d) begin
                frame_cnt  <= frame_cnt + 1;
                owner_hist <= {owner_hist[6:0], current_master};
            end
            for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
                if (rsp[i].valid) begin
                    rsp_cnt[i]   <= rsp_cnt[i] + 1;
                    rsp_data[i]  <= rsp[i].rdata;
                    rsp_stamp[i] <= cycle_q;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic load_cases();
        int           fd;
        string        line;
        logic [127:0] name;
        logic [31:0]  mask;
        logic [31:0]  rw0, id0, ad0, wd0, ex0;
        logic [31:0]  rw1, id1, ad1, wd1, ex1;
        num_cases = 0;
        fd = $fopen("tests/bus_cases.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("could not open the case file tests/bus_cases.txt");
        end else begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines start with a hash
                if (line.len() > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, mask,
                            rw0, id0, ad0, wd0, ex0, rw1, id1, ad1, wd1, ex1) == 12) begin
                    case_name[num_cases] = name;
                    case_mask[num_cases] = mask[1:0];
                    case_cmd[num_cases][0] = {rw0[0], id0[`BUS_ID_W-1:0],
                                              ad0[`BUS_ADDR_W-1:0], wd0[`BUS_DATA_W-1:0]};
                    case_cmd[num_cases][1] = {rw1[0], id1[`BUS_ID_W-1:0],
                                              ad1[`BUS_ADDR_W-1:0], wd1[`BUS_DATA_W-1:0]};
                    case_exp[num_cases][0] = ex0[`BUS_DATA_W-1:0];
                    case_exp[num_cases][1] = ex1[`BUS_DATA_W-1:0];
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // every selected master has answered
    function automatic bit responses_in(input logic [1:0] mask);
        bit done;
        done = 1'b1;
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (mask[i] && rsp_cnt[i] < exp_cnt[i]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic run_case(input int n);
        string tag;
        int    frames;
        int    waited;
        tag    = $sformatf("%0s", case_name[n]);
        frames = frame_cnt;
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (case_mask[n][i]) begin
                cmd[i]     = case_cmd[n][i];
                execute[i] = 1'b1;
                exp_cnt[i]++;
            end
        end
        @(negedge clk);
        execute = '0;
        repeat (3) @(negedge clk);
        // second command while pending, must be dropped
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (case_mask[n][i]) begin
                cmd[i]       = case_cmd[n][i];
                cmd[i].rw    = 1'b1;
                cmd[i].wdata = ~case_cmd[n][i].wdata;
                execute[i]   = 1'b1;
            end
        end
        @(negedge clk);
        execute = '0;
        waited  = 0;
        while (!responses_in(case_mask[n]) && waited < CASE_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (case_mask[n][i] && rsp_cnt[i] != exp_cnt[i]) begin
                err_cnt++;
                $display("master %0d gave %0d responses in case %s, %0d expected",
                         i, rsp_cnt[i], tag, exp_cnt[i]);
                exp_cnt[i] = rsp_cnt[i];
            end else if (case_mask[n][i]) begin
                check_value(tag, 32'(case_exp[n][i]), 32'(rsp_data[i]));
            end
        end
        // both at once, master 0 owns the bus first
        if (case_mask[n] == 2'b11) begin
            if (rsp_stamp[0] >= rsp_stamp[1]) begin
                err_cnt++;
                $display("master 1 answered before master 0 in case %s", tag);
            end
            check_value(tag, 32'd2, 32'(frame_cnt - frames));
            check_value(tag, 32'h1, 32'(owner_hist[1:0]));
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        execute     = '0;
        cmd         = '0;
        err_cnt     = 0;
        check_cnt   = 0;
        table_ready = 1'b0;
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            exp_cnt[i] = 0;
        end
        void'($urandom(32'h864ee9a1));
        load_cases();
        table_ready = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // quiet bus, nothing may answer
        repeat (10) @(negedge clk);
        check_value("reset_rsp0", 32'd0, 32'(rsp_cnt[0]));
        check_value("reset_rsp1", 32'd0, 32'(rsp_cnt[1]));
        check_value("reset_busy", 32'd0, 32'(bus_busy));
        for (int n = 0; n < num_cases; n++) begin
            repeat ($urandom_range(5, 0)) @(negedge clk);
            run_case(n);
        end
        // late frames from dropped commands would show up here
        repeat (40) @(negedge clk);
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (rsp_cnt[i] != exp_cnt[i]) begin
                err_cnt++;
                $display("master %0d gave %0d responses in all, %0d expected",
                         i, rsp_cnt[i], exp_cnt[i]);
            end
        end
        $display("cases %0d, checks %0d, errors %0d", num_cases, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog sized from the case count
    initial begin
        wait (table_ready);
        repeat (num_cases * CASE_CYCLES + 100) @(posedge clk);
        $display("timeout, the run did not end within %0d cycles",
                 num_cases * CASE_CYCLES + 100);
        $display("Finished with errors");
        $finish;
    end

endmodule
